// ==== source/trig_pkg.sv ====
package trig_pkg;

  // ##############################
  // Shared types
  // ##############################

  // Ratio, delay and window counters, SYSREF index, trigger count
  typedef logic [15:0] count_t;

  // Trigger generator states
  typedef enum logic [2:0] {
    calib_wait    = 3'd0,  // Waiting for first SYSREF rise
    calib_measure = 3'd1,  // Counting SYSREF high width
    idle          = 3'd2,
    sysref_wait   = 3'd3,  // Armed, waiting for alignment edge
    delay         = 3'd4,
    fire          = 3'd5   // Trigger window
  } state_t;

  // ##############################
  // Timing constants
  // ##############################

  // Flops in the gpio synchronizer chain
  localparam int sync_stages = 2;

  // Subtracted from half the ratio for the delay limit
  localparam count_t delay_trim = 16'd2;

  // Added to twice the ratio for the trigger width
  localparam count_t window_extra = 16'd4;

  // Smallest ratio with exact alignment timing
  localparam count_t ratio_min = 16'd4;

endpackage

// ==== source/gpio_sync.sv ====
module gpio_sync #(
  parameter int stages = trig_pkg::sync_stages
) (
  input  logic device_clk,
  input  logic rstn,
  input  logic gpio,
  output logic gpio_rise
);

  logic [stages-1:0] sync_q;     // Synchronizer chain, bit 0 is first
  logic              gpio_prev;  // Last synchronized sample

  // ##############################
  // Synchronizer
  // ##############################

  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= gpio;
      for (int i = 1; i < stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // ##############################
  // Rise strobe
  // ##############################

  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      gpio_prev <= 1'b0;
      gpio_rise <= 1'b0;
    end else begin
      gpio_prev <= sync_q[stages-1];
      gpio_rise <= sync_q[stages-1] && !gpio_prev;  // One cycle per edge
    end
  end

endmodule

// ==== source/sysref_monitor.sv ====
module sysref_monitor (
  input  logic             device_clk,
  input  logic             rstn,
  input  logic             sysref,
  input  logic             calib_active,
  output logic             sysref_rise,
  output trig_pkg::count_t ratio,
  output logic             calib_done
);

  logic sysref_r;  // Previous sysref sample

  // ##############################
  // Edge detect
  // ##############################

  // sysref is already in the device_clk domain, one register is enough
  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      sysref_r    <= 1'b0;
      sysref_rise <= 1'b0;
    end else begin
      sysref_r    <= sysref;
      sysref_rise <= sysref && !sysref_r;  // High in cycle after first high sample
    end
  end

  // ##############################
  // Calibration
  // ##############################

  // Counts the high samples that follow the one that raised sysref_rise.
  // The first low sample ends the measurement for good.
  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      ratio      <= '0;
      calib_done <= 1'b0;
    end else begin
      if (calib_active && !calib_done) begin
        if (sysref) begin
          ratio <= ratio + trig_pkg::count_t'(1);
        end else begin
          calib_done <= 1'b1;  // Sticky until reset
        end
      end
    end
  end

endmodule

// ==== source/trigger_fsm.sv ====
module trigger_fsm (
  input  logic             device_clk,
  input  logic             rstn,
  input  logic             sysref_rise,
  input  logic             gpio_rise,
  input  logic             calib_done,
  input  trig_pkg::count_t ratio,
  output logic             calib_active,
  output logic             trigger,
  output logic             fire_start
);

  trig_pkg::state_t state;
  trig_pkg::state_t state_next;
  trig_pkg::count_t delay_cnt;
  trig_pkg::count_t window_cnt;
  trig_pkg::count_t half_ratio;
  trig_pkg::count_t delay_limit;
  trig_pkg::count_t window_limit;

  // ##############################
  // Limits
  // ##############################

  assign half_ratio = ratio >> 1;

  // Clamped at zero for short ratios
  assign delay_limit = (half_ratio > trig_pkg::delay_trim) ?
                       half_ratio - trig_pkg::delay_trim : '0;

  // Last count value of the window, width is twice the ratio plus extra
  assign window_limit = (ratio << 1) + trig_pkg::window_extra - trig_pkg::count_t'(1);

  // ##############################
  // Next state
  // ##############################

  always_comb begin
    state_next = state;
    case (state)
      trig_pkg::calib_wait: begin
        if (sysref_rise) begin
          state_next = trig_pkg::calib_measure;
        end
      end
      trig_pkg::calib_measure: begin
        if (calib_done) begin
          state_next = trig_pkg::idle;
        end
      end
      trig_pkg::idle: begin
        if (gpio_rise) begin
          state_next = trig_pkg::sysref_wait;
        end
      end
      trig_pkg::sysref_wait: begin
        if (sysref_rise) begin
          state_next = trig_pkg::delay;
        end
      end
      trig_pkg::delay: begin
        if (delay_cnt >= delay_limit) begin
          state_next = trig_pkg::fire;
        end
      end
      trig_pkg::fire: begin
        if (window_cnt >= window_limit) begin
          state_next = trig_pkg::idle;
        end
      end
      default: state_next = trig_pkg::calib_wait;
    endcase
  end

  // ##############################
  // State and counters
  // ##############################

  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      state      <= trig_pkg::calib_wait;
      delay_cnt  <= '0;
      window_cnt <= '0;
      trigger    <= 1'b0;
    end else begin
      state   <= state_next;
      trigger <= (state == trig_pkg::fire);  // One cycle behind the state
      if (state_next != state) begin
        delay_cnt  <= '0;  // Fresh count on every entry
        window_cnt <= '0;
      end else begin
        if (state == trig_pkg::delay) begin
          delay_cnt <= delay_cnt + trig_pkg::count_t'(1);
        end
        if (state == trig_pkg::fire) begin
          window_cnt <= window_cnt + trig_pkg::count_t'(1);
        end
      end
    end
  end

  // The first measured sample coincides with the calib_wait exit,
  // so the measurement window opens on sysref_rise already
  assign calib_active = (state == trig_pkg::calib_measure) ||
                        ((state == trig_pkg::calib_wait) && sysref_rise);

  // First fire cycle, trigger goes high on the next edge
  assign fire_start = (state == trig_pkg::fire) && (window_cnt == '0);

endmodule

// ==== source/trigger_stamp.sv ====
module trigger_stamp (
  input  logic             device_clk,
  input  logic             rstn,
  input  logic             calib_done,
  input  logic             sysref_rise,
  input  logic             fire_start,
  output logic             stamp_valid,
  output trig_pkg::count_t stamp_index,
  output trig_pkg::count_t trigger_count
);

  trig_pkg::count_t sysref_count;  // SYSREF rises since calibration

  // ##############################
  // Counters
  // ##############################

  always_ff @(posedge device_clk) begin
    if (!rstn) begin
      sysref_count  <= '0;
      stamp_valid   <= 1'b0;
      trigger_count <= '0;
    end else begin
      // Calibration rise itself is not numbered
      if (calib_done && sysref_rise) begin
        sysref_count <= sysref_count + trig_pkg::count_t'(1);
      end
      stamp_valid <= fire_start;  // Lines up with trigger rise
      if (fire_start) begin
        trigger_count <= trigger_count + trig_pkg::count_t'(1);
      end
    end
  end

  // ##############################
  // Stamp capture
  // ##############################

  // Aligning rise is already counted when fire_start arrives
  always_ff @(posedge device_clk) begin
    if (fire_start) begin
      stamp_index <= sysref_count;
    end
  end

endmodule

// ==== source/trigger_generator.sv ====
module trigger_generator (
  input  logic             device_clk,
  input  logic             rstn,
  input  logic             sysref,
  input  logic             gpio,
  output logic             trigger,
  output logic             calib_done,
  output trig_pkg::count_t ratio,
  output logic             stamp_valid,
  output trig_pkg::count_t stamp_index,
  output trig_pkg::count_t trigger_count
);

  logic gpio_rise;
  logic sysref_rise;
  logic calib_active;
  logic fire_start;

  // ##############################
  // Input side
  // ##############################

  gpio_sync #(
    .stages (trig_pkg::sync_stages)
  ) i_gpio_sync (
    .device_clk (device_clk),
    .rstn       (rstn),
    .gpio       (gpio),
    .gpio_rise  (gpio_rise)
  );

  sysref_monitor i_sysref_monitor (
    .device_clk   (device_clk),
    .rstn         (rstn),
    .sysref       (sysref),
    .calib_active (calib_active),
    .sysref_rise  (sysref_rise),
    .ratio        (ratio),
    .calib_done   (calib_done)
  );

  // ##############################
  // State machine and stamp
  // ##############################

  trigger_fsm i_trigger_fsm (
    .device_clk   (device_clk),
    .rstn         (rstn),
    .sysref_rise  (sysref_rise),
    .gpio_rise    (gpio_rise),
    .calib_done   (calib_done),
    .ratio        (ratio),
    .calib_active (calib_active),
    .trigger      (trigger),
    .fire_start   (fire_start)
  );

  trigger_stamp i_trigger_stamp (
    .device_clk    (device_clk),
    .rstn          (rstn),
    .calib_done    (calib_done),
    .sysref_rise   (sysref_rise),
    .fire_start    (fire_start),
    .stamp_valid   (stamp_valid),
    .stamp_index   (stamp_index),
    .trigger_count (trigger_count)
  );

endmodule

// ==== include/tb_trigger_cases.svh ====
`ifndef TB_TRIGGER_CASES_SVH
`define TB_TRIGGER_CASES_SVH

// ##############################
// Trigger scenarios
// ##############################

// high    SYSREF high width in cycles, ratio is one less
// period  SYSREF period in cycles
// pre     SYSREF periods after calibration before the gpio period
// extra   second gpio edge inside the trigger window
typedef struct packed {
  trig_pkg::count_t high;
  trig_pkg::count_t period;
  logic [7:0]       pre;
  logic             extra;
} case_row_t;

localparam int num_cases = 6;

// Period has to cover delay plus the whole window
function automatic case_row_t get_case(input int idx);
  case_row_t row;
  case (idx)
    0: row = '{high: 16'd5,  period: 16'd24, pre: 8'd0, extra: 1'b0};
    1: row = '{high: 16'd9,  period: 16'd40, pre: 8'd1, extra: 1'b1};
    2: row = '{high: 16'd6,  period: 16'd30, pre: 8'd2, extra: 1'b0};
    3: row = '{high: 16'd13, period: 16'd48, pre: 8'd0, extra: 1'b1};
    4: row = '{high: 16'd8,  period: 16'd36, pre: 8'd3, extra: 1'b1};
    5: row = '{high: 16'd11, period: 16'd44, pre: 8'd1, extra: 1'b0};
    default: row = '{high: 16'd5, period: 16'd24, pre: 8'd0, extra: 1'b0};
  endcase
  return row;
endfunction

// Cycles one row takes with reset, early gpio and SYSREF periods
function automatic int row_cycles(input case_row_t row);
  return 3 + 12 + int'(row.period) * (int'(row.pre) + 4);
endfunction

`endif

// ==== verification/tb_trigger_generator.sv ====
module tb_trigger_generator;

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_trigger_cases.svh"

  logic             device_clk = 1'b0;
  logic             rstn;
  logic             sysref;
  logic             gpio;
  logic             trigger;
  logic             calib_done;
  trig_pkg::count_t ratio;
  logic             stamp_valid;
  trig_pkg::count_t stamp_index;
  trig_pkg::count_t trigger_count;

  int          count_errors = 0;
  int          bit_errors = 0;
  int          cycle_errors = 0;
  int          other_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [15:0] lfsr_state = 16'd10277;

  // edge_n numbers the clock edges seen by the stimulus
  int               edge_n = 0;
  logic             trig_prev;
  int               rise_edge;
  int               fall_edge;
  int               trig_rises;
  int               stamp_pulses;
  logic             stamp_at_rise;
  trig_pkg::count_t index_at_rise;
  int               last_rise_drive;
  int               tb_rises;
  logic             calibrated;

  always #2 device_clk = ~device_clk;

  trigger_generator UUT (
    .device_clk    (device_clk),
    .rstn          (rstn),
    .sysref        (sysref),
    .gpio          (gpio),
    .trigger       (trigger),
    .calib_done    (calib_done),
    .ratio         (ratio),
    .stamp_valid   (stamp_valid),
    .stamp_index   (stamp_index),
    .trigger_count (trigger_count)
  );

  // ##############################
  // Compare and report
  // ##############################

  task automatic check_count(input string name, input trig_pkg::count_t exp,
                             input trig_pkg::count_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      count_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      bit_errors++;
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH at %0t: %s expected %0d cycles, got %0d", $time, name, exp, act);
      cycle_errors++;
    end
  endtask

  task automatic print_error_counts();
    $display("Errors: %0d count, %0d bit, %0d cycles, %0d other", count_errors,
             bit_errors, cycle_errors, other_errors);
  endtask

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // ##############################
  // Stimulus
  // ##############################

  // Samples taken here are the values from before this edge
  task automatic tick();
    @(posedge device_clk);
    edge_n++;
    if (trigger === 1'b1 && trig_prev === 1'b0) begin
      rise_edge     = edge_n - 1;
      trig_rises++;
      stamp_at_rise = stamp_valid;
      index_at_rise = stamp_index;
    end
    if (trigger === 1'b0 && trig_prev === 1'b1) begin
      fall_edge = edge_n - 1;
    end
    if (stamp_valid === 1'b1) begin
      stamp_pulses++;
    end
    trig_prev = trigger;
  endtask

  task automatic apply_reset();
    rstn   <= 1'b0;
    sysref <= 1'b0;
    gpio   <= 1'b0;
    repeat (3) tick();
    check_bit("trigger", 1'b0, trigger);
    check_bit("calib_done", 1'b0, calib_done);
    check_bit("stamp_valid", 1'b0, stamp_valid);
    check_count("ratio", '0, ratio);
    check_count("trigger_count", '0, trigger_count);
    rstn <= 1'b1;
    calibrated    = 1'b0;
    tb_rises      = 0;
    trig_prev     = 1'b0;
    trig_rises    = 0;
    stamp_pulses  = 0;
    stamp_at_rise = 1'b0;
    index_at_rise = '0;
    rise_edge     = 0;
    fall_edge     = 0;
  endtask

  // One SYSREF period with a gpio pulse at gpio_at unless it is negative
  task automatic sysref_period(input int high, input int period, input int gpio_at);
    for (int i = 0; i < period; i++) begin
      tick();
      sysref <= (i < high);
      gpio   <= (gpio_at >= 0) && (i >= gpio_at) && (i < gpio_at + 3);
      if (i == 0) begin
        last_rise_drive = edge_n;
        if (calibrated) begin
          tb_rises++;
        end
      end
    end
  endtask

  task automatic run_row(input int idx);
    case_row_t c;
    int        r;
    int        d;
    int        rnd;
    int        offs;
    int        align_edge;
    int        exp_index;
    c = get_case(idx);
    if (c.high <= trig_pkg::ratio_min) begin
      $display("ERROR: table row %0d has a SYSREF width too short for exact timing", idx);
      other_errors++;
    end
    r = int'(c.high) - 1;
    d = ((r / 2) > int'(trig_pkg::delay_trim)) ? (r / 2) : int'(trig_pkg::delay_trim);
    apply_reset();

    for (int i = 0; i < 12; i++) begin  // gpio before calibration
      tick();
      gpio <= (i < 3);
    end
    sysref_period(c.high, c.period, -1);
    check_bit("calib_done", 1'b1, calib_done);
    check_count("ratio", c.high - 16'd1, ratio);
    check_cycles("trigger pulses before calibration", 0, trig_rises);
    calibrated = 1'b1;

    for (int p = 0; p < int'(c.pre); p++) begin
      sysref_period(c.high, c.period, -1);
    end
    draw_bits(8, rnd);
    offs = int'(c.high) + 1 + rnd % (int'(c.period) - int'(c.high) - 5);
    sysref_period(c.high, c.period, offs);

    // Second gpio of the aligning period lands inside the window
    sysref_period(c.high, c.period, c.extra ? d + 3 : -1);
    align_edge = last_rise_drive + 1;
    exp_index  = tb_rises;
    sysref_period(c.high, c.period, -1);

    check_cycles("trigger latency", 1 + d, rise_edge - align_edge);
    check_cycles("trigger width", 2 * r + int'(trig_pkg::window_extra),
                 fall_edge - rise_edge);
    check_cycles("trigger pulses", 1, trig_rises);
    check_cycles("stamp_valid pulses", 1, stamp_pulses);
    check_bit("stamp_valid", 1'b1, stamp_at_rise);
    check_count("stamp_index", trig_pkg::count_t'(exp_index), index_at_rise);
    check_count("trigger_count", 16'd1, trigger_count);
  endtask

  initial begin
    rstn   = 1'b0;
    sysref = 1'b0;
    gpio   = 1'b0;
    for (int i = 0; i < num_cases; i++) begin
      cycle_limit += row_cycles(get_case(i));
    end
    cycle_limit += 100;
    for (int i = 0; i < num_cases; i++) begin
      run_row(i);
    end
    repeat (4) tick();
    print_error_counts();
    if (count_errors + bit_errors + cycle_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // ##############################
  // Timeout
  // ##############################

  always @(posedge device_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      other_errors++;
      print_error_counts();
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+include
source/trig_pkg.sv
source/gpio_sync.sv
source/sysref_monitor.sv
source/trigger_fsm.sv
source/trigger_stamp.sv
source/trigger_generator.sv
verification/tb_trigger_generator.sv

// ==== Bender.yml ====
package:
  name: trigger_generator

sources:
  - files:
      - source/trig_pkg.sv
      - source/gpio_sync.sv
      - source/sysref_monitor.sv
      - source/trigger_fsm.sv
      - source/trigger_stamp.sv
      - source/trigger_generator.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_trigger_generator.sv
